// ==== design/mem_read_pkg.sv ====
/*
 * Memory read stage shared definitions
 * Field widths, size codes, dependency table depth and the stage payload
 */
package mem_read_pkg;

    localparam int OP_W      = 64;   // Operand width
    localparam int ADDR_W    = 32;   // Low operand bits compared as address
    localparam int IMM_W     = 48;
    localparam int PC_W      = 32;
    localparam int OPC_W     = 16;
    localparam int REG_W     = 3;
    localparam int SIZE_W    = 3;
    localparam int ALU_W     = 4;
    localparam int FLAG_W    = 3;
    localparam int BYTES_W   = 4;    // Byte count up to 8

    // Pending store records
    localparam int DEP_DEPTH = 4;
    localparam int DEP_PTR_W = 2;

    localparam logic [SIZE_W-1:0] SIZE_1B = 3'd0;
    localparam logic [SIZE_W-1:0] SIZE_2B = 3'd1;
    localparam logic [SIZE_W-1:0] SIZE_4B = 3'd2;
    localparam logic [SIZE_W-1:0] SIZE_8B = 3'd3;

    // Byte count of a size code
    function automatic logic [BYTES_W-1:0] size_bytes(input logic [SIZE_W-1:0] size);
        case (size)
            SIZE_1B: return 4'd1;
            SIZE_2B: return 4'd2;
            SIZE_4B: return 4'd4;
            SIZE_8B: return 4'd8;
            default: return 4'd8;    // Codes above 3 act as 8 bytes
        endcase
    endfunction

    typedef struct packed {
        logic [SIZE_W-1:0] size;
        logic              set_d_flag;
        logic              clear_d_flag;
        logic [OP_W-1:0]   op_a;
        logic [OP_W-1:0]   op_b;
        logic [REG_W-1:0]  op_a_reg;
        logic              op_a_is_address;
        logic [IMM_W-1:0]  imm;
        logic [ALU_W-1:0]  alu_op;
        logic [FLAG_W-1:0] flag_0;
        logic [FLAG_W-1:0] flag_1;
        logic [PC_W-1:0]   pc;
        logic              branch_taken;
        logic              to_sys_controller;
        logic [OPC_W-1:0]  opcode;
    } mr_payload_t;

endpackage

// ==== design/addr_dep_table.sv ====
/*
 * Address dependency table
 * Circular FIFO of pending store address ranges, popped by write back,
 * with overlap compare of two read-side operands against every record
 */
module addr_dep_table
    import mem_read_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              push,
    input  logic [ADDR_W-1:0] push_addr,
    input  logic [SIZE_W-1:0] push_size,
    input  logic              pop,
    input  logic [ADDR_W-1:0] cmp_addr0,
    input  logic [ADDR_W-1:0] cmp_addr1,
    input  logic [SIZE_W-1:0] cmp_size,
    output logic              hit0,
    output logic              hit1,
    output logic              full
);

    logic [ADDR_W-1:0]    rec_addr  [DEP_DEPTH];
    logic [BYTES_W-1:0]   rec_bytes [DEP_DEPTH];
    logic [DEP_DEPTH-1:0] rec_valid;
    logic [DEP_PTR_W-1:0] head;
    logic [DEP_PTR_W-1:0] tail;
    logic [DEP_PTR_W:0]   count;
    logic                 do_push;
    logic                 do_pop;
    logic [ADDR_W:0]      cmp_end0;
    logic [ADDR_W:0]      cmp_end1;

    assign full    = (count == (DEP_PTR_W+1)'(DEP_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && (count != '0);    // Pop on empty is dropped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            rec_valid <= '0;
        end else if (flush) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            rec_valid <= '0;
        end else begin
            if (do_push) begin
                rec_valid[tail] <= 1'b1;
                tail            <= tail + 1'b1;
            end
            if (do_pop) begin
                rec_valid[head] <= 1'b0;    // Oldest store has finished
                head            <= head + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            rec_addr[tail]  <= push_addr;
            rec_bytes[tail] <= size_bytes(push_size);
        end
    end

    // Half-open ranges, one extra bit so the end never wraps
    assign cmp_end0 = {1'b0, cmp_addr0} + (ADDR_W+1)'(size_bytes(cmp_size));
    assign cmp_end1 = {1'b0, cmp_addr1} + (ADDR_W+1)'(size_bytes(cmp_size));

    always_comb begin
        logic [ADDR_W:0] rec_start;
        logic [ADDR_W:0] rec_end;
        hit0 = 1'b0;
        hit1 = 1'b0;
        for (int i = 0; i < DEP_DEPTH; i++) begin
            rec_start = {1'b0, rec_addr[i]};
            rec_end   = rec_start + (ADDR_W+1)'(rec_bytes[i]);
            if (rec_valid[i] && ({1'b0, cmp_addr0} < rec_end) && (rec_start < cmp_end0)) begin
                hit0 = 1'b1;
            end
            if (rec_valid[i] && ({1'b0, cmp_addr1} < rec_end) && (rec_start < cmp_end1)) begin
                hit1 = 1'b1;
            end
        end
    end

    // Issue logic must hold address writers back while the table is full
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("push while dependency table full");

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= (DEP_PTR_W+1)'(DEP_DEPTH))
        else $error("dependency table count overflow");

endmodule

// ==== design/pipe_stage.sv ====
/*
 * Single register valid/ready pipeline stage
 * Full throughput hand-off with flush, payload type set by parameter
 */
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic load;

    // Free when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;    // Held item is dropped
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

    // Stalled item must hold until execute takes it
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_data)))
        else $error("pipe stage output changed under back-pressure");

endmodule

// ==== design/mem_read_issue.sv ====
/*
 * Memory read issue logic
 * Applies the address hazard halt, forms the stage payload
 * and pushes new store ranges into the dependency table
 */
module mem_read_issue
    import mem_read_pkg::*;
(
    input  logic              a_valid,
    output logic              a_ready,
    input  logic [SIZE_W-1:0] a_size,
    input  logic              a_set_d_flag,
    input  logic              a_clear_d_flag,
    input  logic [OP_W-1:0]   a_op0,
    input  logic [OP_W-1:0]   a_op1,
    input  logic [REG_W-1:0]  a_op0_reg,
    input  logic              a_op0_is_address,
    input  logic              a_op1_is_address,
    input  logic [IMM_W-1:0]  a_imm,
    input  logic [ALU_W-1:0]  a_alu_op,
    input  logic [FLAG_W-1:0] a_flag_0,
    input  logic [FLAG_W-1:0] a_flag_1,
    input  logic [PC_W-1:0]   a_pc,
    input  logic              a_branch_taken,
    input  logic              a_to_sys_controller,
    input  logic [OPC_W-1:0]  a_opcode,
    input  logic              flush,
    output logic              stage_valid,
    input  logic              stage_ready,
    output mr_payload_t       stage_data,
    output logic              push,
    output logic [ADDR_W-1:0] push_addr,
    output logic [SIZE_W-1:0] push_size,
    output logic [ADDR_W-1:0] cmp_addr0,
    output logic [ADDR_W-1:0] cmp_addr1,
    output logic [SIZE_W-1:0] cmp_size,
    input  logic              hit0,
    input  logic              hit1,
    input  logic              full
);

    logic halt;

    assign cmp_addr0 = a_op0[ADDR_W-1:0];    // Low bits only
    assign cmp_addr1 = a_op1[ADDR_W-1:0];
    assign cmp_size  = a_size;

    // Overlap only matters on operands that really are addresses
    assign halt = (hit0 && a_op0_is_address) || (hit1 && a_op1_is_address)
                || (full && a_op0_is_address);

    assign a_ready     = stage_ready && !halt && !flush;
    assign stage_valid = a_valid && !halt && !flush;

    // Record the destination range as soon as the op enters the stage
    assign push      = a_valid && a_ready && a_op0_is_address;
    assign push_addr = a_op0[ADDR_W-1:0];
    assign push_size = a_size;

    assign stage_data = '{
        size:              a_size,
        set_d_flag:        a_set_d_flag,
        clear_d_flag:      a_clear_d_flag,
        op_a:              a_op0,
        op_b:              a_op1,
        op_a_reg:          a_op0_reg,
        op_a_is_address:   a_op0_is_address,
        imm:               a_imm,
        alu_op:            a_alu_op,
        flag_0:            a_flag_0,
        flag_1:            a_flag_1,
        pc:                a_pc,
        branch_taken:      a_branch_taken,
        to_sys_controller: a_to_sys_controller,
        opcode:            a_opcode
    };

endmodule

// ==== design/mem_read_top.sv ====
/*
 * Memory read stage top
 * Issue logic, address dependency table and one pipe stage toward execute
 */
module mem_read_top
    import mem_read_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              wb_valid,
    input  logic              wb_ready,
    input  logic              wb_to_memory,
    input  logic              a_valid,
    output logic              a_ready,
    input  logic [SIZE_W-1:0] a_size,
    input  logic              a_set_d_flag,
    input  logic              a_clear_d_flag,
    input  logic [OP_W-1:0]   a_op0,
    input  logic [OP_W-1:0]   a_op1,
    input  logic [REG_W-1:0]  a_op0_reg,
    input  logic              a_op0_is_address,
    input  logic              a_op1_is_address,
    input  logic [IMM_W-1:0]  a_imm,
    input  logic [ALU_W-1:0]  a_alu_op,
    input  logic [FLAG_W-1:0] a_flag_0,
    input  logic [FLAG_W-1:0] a_flag_1,
    input  logic [PC_W-1:0]   a_pc,
    input  logic              a_branch_taken,
    input  logic              a_to_sys_controller,
    input  logic [OPC_W-1:0]  a_opcode,
    output logic              e_valid,
    input  logic              e_ready,
    output logic [SIZE_W-1:0] e_size,
    output logic              e_set_d_flag,
    output logic              e_clear_d_flag,
    output logic [OP_W-1:0]   e_op_a,
    output logic [OP_W-1:0]   e_op_b,
    output logic [REG_W-1:0]  e_op_a_reg,
    output logic              e_op_a_is_address,
    output logic [IMM_W-1:0]  e_imm,
    output logic [ALU_W-1:0]  e_alu_op,
    output logic [FLAG_W-1:0] e_flag_0,
    output logic [FLAG_W-1:0] e_flag_1,
    output logic [PC_W-1:0]   e_pc,
    output logic              e_branch_taken,
    output logic              e_to_sys_controller,
    output logic [OPC_W-1:0]  e_opcode
);

    logic              in_valid;
    logic              in_ready;
    mr_payload_t       in_data;
    mr_payload_t       out_data;
    logic              push;
    logic [ADDR_W-1:0] push_addr;
    logic [SIZE_W-1:0] push_size;
    logic              pop;
    logic [ADDR_W-1:0] cmp_addr0;
    logic [ADDR_W-1:0] cmp_addr1;
    logic [SIZE_W-1:0] cmp_size;
    logic              hit0;
    logic              hit1;
    logic              full;

    // Completed store from write back
    assign pop = wb_valid && wb_ready && wb_to_memory;

    mem_read_issue issue0 (
        .a_valid             (a_valid),
        .a_ready             (a_ready),
        .a_size              (a_size),
        .a_set_d_flag        (a_set_d_flag),
        .a_clear_d_flag      (a_clear_d_flag),
        .a_op0               (a_op0),
        .a_op1               (a_op1),
        .a_op0_reg           (a_op0_reg),
        .a_op0_is_address    (a_op0_is_address),
        .a_op1_is_address    (a_op1_is_address),
        .a_imm               (a_imm),
        .a_alu_op            (a_alu_op),
        .a_flag_0            (a_flag_0),
        .a_flag_1            (a_flag_1),
        .a_pc                (a_pc),
        .a_branch_taken      (a_branch_taken),
        .a_to_sys_controller (a_to_sys_controller),
        .a_opcode            (a_opcode),
        .flush               (flush),
        .stage_valid         (in_valid),
        .stage_ready         (in_ready),
        .stage_data          (in_data),
        .push                (push),
        .push_addr           (push_addr),
        .push_size           (push_size),
        .cmp_addr0           (cmp_addr0),
        .cmp_addr1           (cmp_addr1),
        .cmp_size            (cmp_size),
        .hit0                (hit0),
        .hit1                (hit1),
        .full                (full)
    );

    addr_dep_table dep_table0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .push      (push),
        .push_addr (push_addr),
        .push_size (push_size),
        .pop       (pop),
        .cmp_addr0 (cmp_addr0),
        .cmp_addr1 (cmp_addr1),
        .cmp_size  (cmp_size),
        .hit0      (hit0),
        .hit1      (hit1),
        .full      (full)
    );

    pipe_stage #(
        .payload_t (mr_payload_t)
    ) stage0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (e_valid),
        .out_ready (e_ready),
        .out_data  (out_data)
    );

    // Execute side fields
    assign e_size              = out_data.size;
    assign e_set_d_flag        = out_data.set_d_flag;
    assign e_clear_d_flag      = out_data.clear_d_flag;
    assign e_op_a              = out_data.op_a;
    assign e_op_b              = out_data.op_b;
    assign e_op_a_reg          = out_data.op_a_reg;
    assign e_op_a_is_address   = out_data.op_a_is_address;
    assign e_imm               = out_data.imm;
    assign e_alu_op            = out_data.alu_op;
    assign e_flag_0            = out_data.flag_0;
    assign e_flag_1            = out_data.flag_1;
    assign e_pc                = out_data.pc;
    assign e_branch_taken      = out_data.branch_taken;
    assign e_to_sys_controller = out_data.to_sys_controller;
    assign e_opcode            = out_data.opcode;

endmodule

// ==== sim/mem_read_tb.sv ====
/*
 * Memory read stage testbench
 * Table-driven stimulus with a model of pending stores and expected payloads
 */
module mem_read_tb
    import mem_read_pkg::*;
();

    typedef enum logic [1:0] {K_OP, K_WB, K_FLUSH, K_IDLE} kind_e;

    typedef struct {
        kind_e             kind;
        logic [SIZE_W-1:0] size;
        logic [ADDR_W-1:0] addr0;
        logic [ADDR_W-1:0] addr1;
        logic              is0;     // op0 is an address
        logic              is1;     // op1 is an address
        int                n;       // OP: cycle of the store completion, IDLE: length
        logic              e_hold;  // Keep execute stalled during the step
    } step_t;

    localparam int NSTEPS  = 28;
    localparam int TIMEOUT = (NSTEPS * 40 + 100) * 20;

    // kind, size, addr0, addr1, is0, is1, n, e_hold
    step_t steps [NSTEPS] = '{
        '{K_OP,    SIZE_1B, 32'h0000_0100, 32'h0000_0200, 1'b0, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_2B, 32'h0000_0104, 32'h0000_0204, 1'b0, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_4B, 32'h0000_0108, 32'h0000_0208, 1'b0, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_8B, 32'h0000_010c, 32'h0000_020c, 1'b0, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_4B, 32'h0000_1000, 32'h0000_0000, 1'b1, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_4B, 32'h0000_0300, 32'h0000_1000, 1'b0, 1'b1, 3, 1'b0},
        '{K_OP,    SIZE_4B, 32'h0000_2000, 32'h0000_0000, 1'b1, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_2B, 32'h0000_0300, 32'h0000_2004, 1'b0, 1'b1, 0, 1'b0},
        '{K_OP,    SIZE_2B, 32'h0000_0300, 32'h0000_2002, 1'b0, 1'b1, 3, 1'b0},
        '{K_OP,    SIZE_4B, 32'h0000_2000, 32'h0000_0000, 1'b1, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_8B, 32'h0000_0300, 32'h0000_1ffc, 1'b0, 1'b1, 3, 1'b0},
        '{K_OP,    SIZE_8B, 32'h0000_4000, 32'h0000_0000, 1'b1, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_4B, 32'h0000_4000, 32'h0000_4004, 1'b0, 1'b0, 0, 1'b0},
        '{K_WB,    SIZE_1B, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_8B, 32'h0000_5000, 32'h0000_0000, 1'b1, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_8B, 32'h0000_5010, 32'h0000_0000, 1'b1, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_8B, 32'h0000_5020, 32'h0000_0000, 1'b1, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_8B, 32'h0000_5030, 32'h0000_0000, 1'b1, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_8B, 32'h0000_0400, 32'h0000_5000, 1'b0, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_8B, 32'h0000_6000, 32'h0000_0000, 1'b1, 1'b0, 3, 1'b0},
        '{K_IDLE,  SIZE_1B, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 3, 1'b0},
        '{K_OP,    SIZE_4B, 32'h0000_0500, 32'h0000_0600, 1'b0, 1'b0, 0, 1'b1},
        '{K_FLUSH, SIZE_1B, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_8B, 32'h0000_0700, 32'h0000_5010, 1'b0, 1'b1, 0, 1'b0},
        '{K_WB,    SIZE_1B, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_2B, 32'h0000_7000, 32'h0000_0000, 1'b1, 1'b0, 0, 1'b0},
        '{K_OP,    SIZE_1B, 32'h0000_0800, 32'h0000_7001, 1'b0, 1'b1, 2, 1'b0},
        '{K_IDLE,  SIZE_1B, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 4, 1'b0}
    };

    logic              clk, rst_n, flush;
    logic              wb_valid, wb_ready, wb_to_memory;
    logic              a_valid, a_ready, e_valid, e_ready;
    logic [SIZE_W-1:0] a_size, e_size;
    logic              a_set_d_flag, a_clear_d_flag, e_set_d_flag, e_clear_d_flag;
    logic [OP_W-1:0]   a_op0, a_op1, e_op_a, e_op_b;
    logic [REG_W-1:0]  a_op0_reg, e_op_a_reg;
    logic              a_op0_is_address, a_op1_is_address, e_op_a_is_address;
    logic [IMM_W-1:0]  a_imm, e_imm;
    logic [ALU_W-1:0]  a_alu_op, e_alu_op;
    logic [FLAG_W-1:0] a_flag_0, a_flag_1, e_flag_0, e_flag_1;
    logic [PC_W-1:0]   a_pc, e_pc;
    logic              a_branch_taken, a_to_sys_controller;
    logic              e_branch_taken, e_to_sys_controller;
    logic [OPC_W-1:0]  a_opcode, e_opcode;

    mr_payload_t observed;
    mr_payload_t exp_q [$];     // Accepted ops still owed to execute
    longint      pend_start [$];
    longint      pend_end [$];  // Half-open store ranges, oldest first
    int          mismatches = 0;
    int          other_errors = 0;

    mem_read_top dut0 (.*);

    assign observed = '{size: e_size, set_d_flag: e_set_d_flag, clear_d_flag: e_clear_d_flag,
        op_a: e_op_a, op_b: e_op_b, op_a_reg: e_op_a_reg, op_a_is_address: e_op_a_is_address,
        imm: e_imm, alu_op: e_alu_op, flag_0: e_flag_0, flag_1: e_flag_1, pc: e_pc,
        branch_taken: e_branch_taken, to_sys_controller: e_to_sys_controller,
        opcode: e_opcode};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("ERROR: run timed out after %0d time units", TIMEOUT);
        $display("=== FAIL ===");
        $finish;
    end

    // Read-side fields map straight onto the payload, op0 to op_a and op1 to op_b
    function automatic mr_payload_t input_payload();
        return '{size: a_size, set_d_flag: a_set_d_flag, clear_d_flag: a_clear_d_flag,
            op_a: a_op0, op_b: a_op1, op_a_reg: a_op0_reg, op_a_is_address: a_op0_is_address,
            imm: a_imm, alu_op: a_alu_op, flag_0: a_flag_0, flag_1: a_flag_1, pc: a_pc,
            branch_taken: a_branch_taken, to_sys_controller: a_to_sys_controller,
            opcode: a_opcode};
    endfunction

    function automatic logic overlaps(input logic [ADDR_W-1:0] addr,
                                      input logic [SIZE_W-1:0] size);
        longint lo;
        longint hi;
        lo = longint'(addr);
        hi = lo + longint'(size_bytes(size));
        foreach (pend_start[i]) begin
            if (lo < pend_end[i] && pend_start[i] < hi) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic hazard();
        logic table_full;
        table_full = (pend_start.size() == DEP_DEPTH);
        return (a_op0_is_address && (overlaps(a_op0[ADDR_W-1:0], a_size) || table_full))
            || (a_op1_is_address && overlaps(a_op1[ADDR_W-1:0], a_size));
    endfunction

    function automatic logic rand_ready();
        return ($urandom % 10) < 7;    // About 70 percent high
    endfunction

    task automatic check_ready(input string name, input logic want, input logic got);
        if (got !== want) begin
            mismatches++;
            $display("MISMATCH %s exp=%h got=%h at %0t", name, want, got, $time);
        end
    endtask

    task automatic check_field(input string name, input logic [OP_W-1:0] want,
                               input logic [OP_W-1:0] got);
        if (got !== want) begin
            mismatches++;
            $display("MISMATCH %s exp=%h got=%h at %0t", name, want, got, $time);
        end
    endtask

    task automatic check_payload(input mr_payload_t want, input mr_payload_t got);
        check_field("e_size", OP_W'(want.size), OP_W'(got.size));
        check_field("e_set_d_flag", OP_W'(want.set_d_flag), OP_W'(got.set_d_flag));
        check_field("e_clear_d_flag", OP_W'(want.clear_d_flag), OP_W'(got.clear_d_flag));
        check_field("e_op_a", want.op_a, got.op_a);
        check_field("e_op_b", want.op_b, got.op_b);
        check_field("e_op_a_reg", OP_W'(want.op_a_reg), OP_W'(got.op_a_reg));
        check_field("e_op_a_is_address", OP_W'(want.op_a_is_address),
                    OP_W'(got.op_a_is_address));
        check_field("e_imm", OP_W'(want.imm), OP_W'(got.imm));
        check_field("e_alu_op", OP_W'(want.alu_op), OP_W'(got.alu_op));
        check_field("e_flag_0", OP_W'(want.flag_0), OP_W'(got.flag_0));
        check_field("e_flag_1", OP_W'(want.flag_1), OP_W'(got.flag_1));
        check_field("e_pc", OP_W'(want.pc), OP_W'(got.pc));
        check_field("e_branch_taken", OP_W'(want.branch_taken), OP_W'(got.branch_taken));
        check_field("e_to_sys_controller", OP_W'(want.to_sys_controller),
                    OP_W'(got.to_sys_controller));
        check_field("e_opcode", OP_W'(want.opcode), OP_W'(got.opcode));
    endtask

    task automatic clear_inputs();
        flush = 1'b0;
        {wb_valid, wb_ready, wb_to_memory} = 3'b000;
        {a_valid, a_set_d_flag, a_clear_d_flag, a_branch_taken, a_to_sys_controller} = '0;
        {a_op0_is_address, a_op1_is_address} = 2'b00;
        a_size    = '0;
        a_op0     = '0;
        a_op1     = '0;
        a_op0_reg = '0;
        a_imm     = '0;
        a_alu_op  = '0;
        a_flag_0  = '0;
        a_flag_1  = '0;
        a_pc      = '0;
        a_opcode  = '0;
    endtask

    task automatic load_op(input step_t st);
        a_valid             = 1'b1;
        a_size              = st.size;
        a_op0               = {$urandom, st.addr0};    // Upper half never compared
        a_op1               = {$urandom, st.addr1};
        a_op0_is_address    = st.is0;
        a_op1_is_address    = st.is1;
        a_set_d_flag        = 1'($urandom);
        a_clear_d_flag      = 1'($urandom);
        a_op0_reg           = REG_W'($urandom);
        a_imm               = {16'($urandom), $urandom};
        a_alu_op            = ALU_W'($urandom);
        a_flag_0            = FLAG_W'($urandom);
        a_flag_1            = FLAG_W'($urandom);
        a_pc                = $urandom;
        a_branch_taken      = 1'($urandom);
        a_to_sys_controller = 1'($urandom);
        a_opcode            = OPC_W'($urandom);
    endtask

    // Check mid cycle, then advance the model past the next rising edge
    task automatic run_cycle(output logic accepted);
        logic exp_valid;
        logic exp_ready;
        logic store_done;
        @(negedge clk);
        exp_valid = (exp_q.size() != 0);
        exp_ready = (!exp_valid || e_ready) && !flush && !hazard();
        check_ready("e_valid", exp_valid, e_valid);
        check_ready("a_ready", exp_ready, a_ready);
        if (exp_valid && e_valid) begin
            check_payload(exp_q[0], observed);
        end
        accepted   = a_valid && a_ready;    // Read-side transfer as the DUT sees it
        store_done = wb_valid && wb_ready && wb_to_memory;
        if (exp_valid && e_ready) begin
            void'(exp_q.pop_front());
        end
        if (flush) begin
            exp_q.delete();
            pend_start.delete();
            pend_end.delete();
        end else begin
            if (store_done && pend_start.size() != 0) begin
                void'(pend_start.pop_front());
                void'(pend_end.pop_front());
            end
            if (accepted) begin
                exp_q.push_back(input_payload());
                if (a_op0_is_address) begin
                    pend_start.push_back(longint'(a_op0[ADDR_W-1:0]));
                    pend_end.push_back(longint'(a_op0[ADDR_W-1:0]) + size_bytes(a_size));
                end
            end
        end
        @(posedge clk);
        #2;
    endtask

    task automatic apply_step(input int idx);
        step_t st;
        logic  accepted;
        int    c;
        st = steps[idx];
        c  = 0;
        case (st.kind)
            K_OP: begin
                load_op(st);
                accepted = 1'b0;
                while (!accepted) begin
                    e_ready      = st.e_hold ? 1'b0 : rand_ready();
                    wb_valid     = (st.n != 0 && c == st.n);    // Store completes here
                    wb_ready     = wb_valid;
                    wb_to_memory = wb_valid;
                    run_cycle(accepted);
                    c++;
                end
                if (st.n != 0 && c <= st.n + 1) begin
                    other_errors++;
                    $display("ERROR: step %0d was accepted before its store completed", idx);
                end
            end
            K_WB: begin
                {wb_valid, wb_ready, wb_to_memory} = 3'b111;
                e_ready = rand_ready();
                run_cycle(accepted);
            end
            K_FLUSH: begin
                flush   = 1'b1;
                e_ready = 1'b0;    // Held item must be dropped, not taken
                run_cycle(accepted);
            end
            default: begin
                repeat (st.n) begin
                    e_ready = 1'b1;
                    {wb_valid, wb_ready, wb_to_memory} = 3'b110;    // Not a store
                    run_cycle(accepted);
                end
            end
        endcase
        clear_inputs();
    endtask

    initial begin
        void'($urandom(32));
        rst_n   = 1'b0;
        e_ready = 1'b0;
        clear_inputs();
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < NSTEPS; i++) begin
            apply_step(i);
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("ERROR: %0d accepted operations never left the stage", exp_q.size());
        end
        $display("mismatches=%0d other_errors=%0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== mem_read_top.f ====
design/mem_read_pkg.sv
design/addr_dep_table.sv
design/pipe_stage.sv
design/mem_read_issue.sv
design/mem_read_top.sv
sim/mem_read_tb.sv

// ==== Bender.yml ====
package:
  name: mem_read

sources:
  - files:
      - design/mem_read_pkg.sv
      - design/addr_dep_table.sv
      - design/pipe_stage.sv
      - design/mem_read_issue.sv
      - design/mem_read_top.sv
  - target: test
    files:
      - sim/mem_read_tb.sv
